// ==== lsq_settings.svh ====
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// Queue slots
`define LSQ_DEPTH 4
// Head/tail pointer width
`define LSQ_PTR_W $clog2(`LSQ_DEPTH)

// Address and data width
`define XLEN 32

// ROB tag width, tag 0 reserved as none
`define TAG_W 4

// Data memory depth in words
`define MEM_WORDS 64
// Word index width, taken from address bits above the byte offset
`define MEM_IDX_W $clog2(`MEM_WORDS)

`endif

// ==== lsq_pkg.sv ====
`default_nettype none

`include "lsq_settings.svh"

package lsq_pkg;

    // One broadcast on the common data bus
    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;      // Producer ROB tag
        logic [`XLEN-1:0]  result;
    } cdb_packet_t;

    // One load/store queue entry
    typedef struct packed {
        logic              load;           // 1 load, 0 store
        logic [`TAG_W-1:0] rob_tag;        // Own tag, its CDB result is the address
        logic              address_valid;
        logic [`XLEN-1:0]  address;
        logic [`TAG_W-1:0] q_store;        // Store data producer, 0 once data is in
        logic [`XLEN-1:0]  data;
    } lsq_packet_t;

    // One data memory access
    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic [`MEM_IDX_W-1:0] index;    // Word index
        logic [`XLEN-1:0]      wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== lsq_entry.sv ====
`default_nettype none
`timescale 1ns/100ps

module lsq_entry (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fill,        // Dispatch writes this slot
    input  lsq_pkg::lsq_packet_t fill_entry,
    input  logic                 clear,       // Head retired, free the slot
    input  lsq_pkg::cdb_packet_t cdb_in,
    output lsq_pkg::lsq_packet_t entry,
    output logic                 ready
);

    logic occupied;
    logic addr_hit;     // CDB carries our address
    logic data_hit;     // CDB carries our store data

    // Tag 0 never names a producer
    assign addr_hit = cdb_in.valid && (entry.rob_tag != '0) &&
                      (cdb_in.tag == entry.rob_tag);
    assign data_hit = cdb_in.valid && (entry.q_store != '0) &&
                      (cdb_in.tag == entry.q_store);

    // Address known and nothing left to wait on
    assign ready = occupied && entry.address_valid && (entry.q_store == '0);

    // Slot occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= 1'b0;
        end else if (fill) begin
            occupied <= 1'b1;
        end else if (clear) begin
            occupied <= 1'b0;
        end
    end

    // Entry payload, filled by dispatch then completed from the CDB
    always_ff @(posedge clk) begin
        if (fill) begin
            entry <= fill_entry;
        end else if (occupied) begin
            if (addr_hit) begin
                entry.address       <= cdb_in.result;
                entry.address_valid <= 1'b1;
            end
            if (data_hit) begin
                entry.data    <= cdb_in.result;
                entry.q_store <= '0;             // Data now present
            end
        end
    end

    // Allocator must only hand out free slots
    a_fill_free: assert property (
        @(posedge clk) disable iff (reset)
        fill |-> !occupied
    ) else $error("lsq_entry: fill into occupied slot");

endmodule

`default_nettype wire

// ==== lsq_alloc.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "lsq_settings.svh"

module lsq_alloc (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enq,    // Dispatch offers an entry
    input  logic                  pop,    // Retire freed the head slot
    output logic [`LSQ_DEPTH-1:0] fill,   // One-hot slot write strobe
    output logic                  full
);

    localparam int CNT_W = $clog2(`LSQ_DEPTH + 1);
    localparam int LAST  = `LSQ_DEPTH - 1;

    logic [`LSQ_PTR_W-1:0] tail;     // Next free slot
    logic [CNT_W-1:0]      count;    // Occupied slots, all DEPTH usable
    logic                  accept;

    assign full   = (count == CNT_W'(`LSQ_DEPTH));
    assign accept = enq && !full;    // Enq while full is dropped

    always_comb begin
        fill       = '0;
        fill[tail] = accept;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                tail <= (tail == LAST[`LSQ_PTR_W-1:0]) ? '0 : tail + 1'b1;   // Wrap
            end
            case ({accept, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;             // Both or neither
            endcase
        end
    end

    // Also catches a pop on an empty queue, which wraps the count
    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= CNT_W'(`LSQ_DEPTH)
    ) else $error("lsq_alloc: occupancy count out of range");

endmodule

`default_nettype wire

// ==== lsq_retire.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "lsq_settings.svh"

module lsq_retire (
    input  logic                  clk,
    input  logic                  reset,
    input  lsq_pkg::lsq_packet_t  entries [`LSQ_DEPTH],
    input  logic [`LSQ_DEPTH-1:0] ready,
    input  logic                  store_commit,     // ROB head is this store
    input  logic                  cdb_grant,
    input  logic [`XLEN-1:0]      rd_data,
    output logic                  pop,
    output logic [`LSQ_DEPTH-1:0] clear,
    output lsq_pkg::mem_req_t     mem_req,
    output logic                  head_store_ready,
    output lsq_pkg::cdb_packet_t  load_out
);
    import lsq_pkg::*;

    localparam int LAST = `LSQ_DEPTH - 1;

    typedef enum logic [1:0] {
        S_IDLE,     // Free to retire the head
        S_READ,     // Load read in flight
        S_HOLD      // Load result waiting for CDB grant
    } state_t;

    state_t                state;
    logic [`LSQ_PTR_W-1:0] head;
    lsq_packet_t           head_entry;
    logic                  head_ready;
    logic                  start_load;
    logic                  commit_store;
    logic [`TAG_W-1:0]     out_tag;       // Held load result payload
    logic [`XLEN-1:0]      out_result;

    assign head_entry = entries[head];
    assign head_ready = ready[head];

    assign head_store_ready = head_ready && !head_entry.load;

    // Nothing retires unless idle, so never while a result is held
    assign start_load   = (state == S_IDLE) && head_ready && head_entry.load;
    assign commit_store = (state == S_IDLE) && head_store_ready && store_commit;

    // Load pops with its result, store pops with its write
    assign pop = (state == S_READ) || commit_store;

    always_comb begin
        clear       = '0;
        clear[head] = pop;
    end

    always_comb begin
        mem_req.rd    = start_load;
        mem_req.wr    = commit_store;
        mem_req.index = head_entry.address[`MEM_IDX_W+1:2];   // Drop byte offset
        mem_req.wdata = head_entry.data;
    end

    assign load_out = '{valid: (state == S_HOLD), tag: out_tag, result: out_result};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            head  <= '0;
        end else begin
            if (pop) begin
                head <= (head == LAST[`LSQ_PTR_W-1:0]) ? '0 : head + 1'b1;
            end
            case (state)
                S_IDLE:  if (start_load) state <= S_READ;
                S_READ:  state <= S_HOLD;               // Memory word arrived
                S_HOLD:  if (cdb_grant) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Capture the load result as it leaves memory
    always_ff @(posedge clk) begin
        if (state == S_READ) begin
            out_tag    <= head_entry.rob_tag;
            out_result <= rd_data;
        end
    end

    // The slot must still be complete when it leaves the queue
    a_pop_ready: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> head_ready
    ) else $error("lsq_retire: pop of an unready head");

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "lsq_settings.svh"

module data_mem (
    input  logic                 clk,
    input  lsq_pkg::mem_req_t    mem_req,
    output logic [`XLEN-1:0]     rd_data    // Valid the cycle after rd
);

    logic [`XLEN-1:0] mem [`MEM_WORDS];

    // Power-up contents zero
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.wr) begin
            mem[mem_req.index] <= mem_req.wdata;
        end
    end

    // Registered read, holds last value between reads
    always_ff @(posedge clk) begin
        if (mem_req.rd) begin
            rd_data <= mem[mem_req.index];
        end
    end

    // Retire picks one access per cycle
    a_rd_wr_excl: assert property (
        @(posedge clk)
        mem_req.rd |-> !mem_req.wr
    ) else $error("data_mem: read and write in one cycle");

endmodule

`default_nettype wire

// ==== lsq_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "lsq_settings.svh"

module lsq_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enq,
    input  lsq_pkg::lsq_packet_t enq_entry,
    input  lsq_pkg::cdb_packet_t cdb_in,
    input  logic                 store_commit,
    input  logic                 cdb_grant,
    output logic                 full,
    output logic                 head_store_ready,
    output lsq_pkg::cdb_packet_t load_out
);
    import lsq_pkg::*;

    logic [`LSQ_DEPTH-1:0] fill;       // Allocator to slots
    logic [`LSQ_DEPTH-1:0] clear;      // Retire to slots
    logic [`LSQ_DEPTH-1:0] ready;
    logic                  pop;
    lsq_packet_t           entries [`LSQ_DEPTH];
    mem_req_t              mem_req;
    logic [`XLEN-1:0]      rd_data;

    lsq_alloc u_alloc (
        .clk   (clk),
        .reset (reset),
        .enq   (enq),
        .pop   (pop),
        .fill  (fill),
        .full  (full)
    );

    // Identical slots, each snooping the CDB
    for (genvar i = 0; i < `LSQ_DEPTH; i++) begin : g_slot
        lsq_entry u_entry (
            .clk        (clk),
            .reset      (reset),
            .fill       (fill[i]),
            .fill_entry (enq_entry),
            .clear      (clear[i]),
            .cdb_in     (cdb_in),
            .entry      (entries[i]),
            .ready      (ready[i])
        );
    end

    lsq_retire u_retire (
        .clk              (clk),
        .reset            (reset),
        .entries          (entries),
        .ready            (ready),
        .store_commit     (store_commit),
        .cdb_grant        (cdb_grant),
        .rd_data          (rd_data),
        .pop              (pop),
        .clear            (clear),
        .mem_req          (mem_req),
        .head_store_ready (head_store_ready),
        .load_out         (load_out)
    );

    data_mem u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== lsq_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "lsq_settings.svh"

module lsq_tb;
    import lsq_pkg::*;

    localparam int NUM_OPS    = 51;     // Enqueues over all tests including the ignored one
    localparam int CYC_PER_OP = 20;
    localparam int MAX_CYCLES = NUM_OPS * CYC_PER_OP;
    localparam int RAND_OPS   = 40;

    logic        clk = 1'b0;
    logic        reset;
    logic        enq;
    lsq_packet_t enq_entry;
    cdb_packet_t cdb_in;
    logic        store_commit;
    logic        cdb_grant;
    logic        full;
    logic        head_store_ready;
    cdb_packet_t load_out;

    logic [`XLEN-1:0] model_mem [`MEM_WORDS];   // Memory as program order sees it
    cdb_packet_t      exp_q[$];                 // Loads still owed a result in age order
    cdb_packet_t      bcast_q[$];               // CDB packets not yet sent
    logic             rand_mode = 1'b0;         // Grant and commit from $urandom
    int               errors = 0;
    int               checks = 0;
    int               results = 0;              // Accepted load_out packets
    int               tests = 0;
    int               cycles = 0;
    int               test_errors;

    lsq_top uut (
        .clk              (clk),
        .reset            (reset),
        .enq              (enq),
        .enq_entry        (enq_entry),
        .cdb_in           (cdb_in),
        .store_commit     (store_commit),
        .cdb_grant        (cdb_grant),
        .full             (full),
        .head_store_ready (head_store_ready),
        .load_out         (load_out)
    );

    always #10 clk = ~clk;

    // Word index with the byte offset dropped
    function automatic int word_of(input logic [`XLEN-1:0] addr);
        return int'((addr >> 2) % `MEM_WORDS);
    endfunction

    // Load value after every earlier store in program order
    function automatic logic [`XLEN-1:0] expected_load(input logic [`XLEN-1:0] addr);
        return model_mem[word_of(addr)];
    endfunction

    function automatic lsq_packet_t make_entry(input logic is_load,
                                               input logic [`TAG_W-1:0] tag,
                                               input logic [`TAG_W-1:0] dtag,
                                               input logic [`XLEN-1:0] data);
        lsq_packet_t e;
        e         = '0;
        e.load    = is_load;
        e.rob_tag = tag;                  // Address comes later on the CDB
        if (!is_load) begin
            e.q_store = dtag;
            e.data    = (dtag == '0) ? data : '0;   // Known data rides along
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        assert (got == want) else begin
            $display("ERR %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    // One dispatch that queues the CDB packets this op will need
    task automatic enqueue_op(input logic is_load, input logic [`TAG_W-1:0] tag,
                              input logic [`XLEN-1:0] addr,
                              input logic [`TAG_W-1:0] dtag,
                              input logic [`XLEN-1:0] data);
        while (full) @(negedge clk);
        enq       = 1'b1;
        enq_entry = make_entry(is_load, tag, dtag, data);
        @(negedge clk);
        enq = 1'b0;
        bcast_q.push_back('{valid: 1'b1, tag: tag, result: addr});
        if (is_load) begin
            exp_q.push_back('{valid: 1'b1, tag: tag, result: expected_load(addr)});
        end else begin
            model_mem[word_of(addr)] = data;
            if (dtag != '0) begin
                bcast_q.push_back('{valid: 1'b1, tag: dtag, result: data});
            end
        end
    endtask

    task automatic send_broadcasts(input bit shuffle, input int max_gap);
        cdb_packet_t tmp;
        int          j;
        if (shuffle) begin
            for (int i = bcast_q.size() - 1; i > 0; i--) begin
                j          = int'($urandom % (i + 1));
                tmp        = bcast_q[i];
                bcast_q[i] = bcast_q[j];
                bcast_q[j] = tmp;
            end
        end
        while (bcast_q.size() != 0) begin
            cdb_in = bcast_q.pop_front();
            @(negedge clk);
            cdb_in = '0;
            if (max_gap > 0) begin
                repeat (int'($urandom % (max_gap + 1))) @(negedge clk);   // Idle bus
            end
        end
    endtask

    // Broadcasts are done so a ready store at the head means work is left
    task automatic wait_idle();
        while (exp_q.size() != 0 || head_store_ready || load_out.valid) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
        end
    endtask

    // Cycle limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the queue did not drain", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // ROB side in the random test
    always @(negedge clk) begin
        if (rand_mode) begin
            cdb_grant    = ($urandom % 3) != 0;    // Gap about one cycle in three
            store_commit = ($urandom % 2) != 0;
        end
    end

    // Every granted result against the oldest owed load
    always @(posedge clk) begin
        cdb_packet_t want;
        if (!reset && load_out.valid && cdb_grant) begin
            results++;
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("Load result with tag %h arrived with no load owed", load_out.tag);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                check_value("load_out.tag", 64'(load_out.tag), 64'(want.tag));
                check_value("load_out.result", 64'(load_out.result), 64'(want.result));
            end
        end
    end

    initial begin
        cdb_packet_t      held;
        int               base;
        int               remaining;
        int               n;
        logic             is_load;
        logic [`TAG_W-1:0] dtag;
        logic [`XLEN-1:0] addr;

        void'($urandom(32'hb76));
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        reset        = 1'b1;
        enq          = 1'b0;
        enq_entry    = '0;
        cdb_in       = '0;
        store_commit = 1'b0;
        cdb_grant    = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        test_errors = errors;
        check_value("full", 64'(full), 64'(0));
        check_value("head_store_ready", 64'(head_store_ready), 64'(0));
        check_value("load_out.valid", 64'(load_out.valid), 64'(0));
        report_test("reset state");

        test_errors = errors;
        base        = results;
        for (int i = 1; i <= `LSQ_DEPTH; i++) begin
            enqueue_op(1'b1, `TAG_W'(i), `XLEN'(32'h100 + 4 * i), '0, '0);
        end
        check_value("full", 64'(full), 64'(1));
        enq       = 1'b1;                                  // Dropped and kept out of the model
        enq_entry = make_entry(1'b1, `TAG_W'(`LSQ_DEPTH + 1), '0, '0);
        @(negedge clk);
        enq = 1'b0;
        bcast_q.push_back('{valid: 1'b1, tag: `TAG_W'(`LSQ_DEPTH + 1), result: 32'h200});
        send_broadcasts(1'b0, 0);
        wait_idle();
        repeat (5) @(negedge clk);
        check_value("load results", 64'(results - base), 64'(`LSQ_DEPTH));
        report_test("capacity");

        test_errors = errors;
        enqueue_op(1'b0, 4'd1, 32'h40, 4'd2, 32'hcafe_0123);
        enqueue_op(1'b1, 4'd3, 32'h40, '0, '0);
        enqueue_op(1'b1, 4'd4, 32'h84, '0, '0);           // Never written
        send_broadcasts(1'b1, 1);
        while (!head_store_ready) @(negedge clk);
        check_value("load_out.valid", 64'(load_out.valid), 64'(0));   // Loads wait behind it
        store_commit = 1'b1;
        wait_idle();
        report_test("store then load");

        test_errors = errors;
        enqueue_op(1'b1, 4'd5, 32'h40, '0, '0);
        repeat (10) begin
            @(negedge clk);
            check_value("load_out.valid", 64'(load_out.valid), 64'(0));
        end
        send_broadcasts(1'b0, 0);
        wait_idle();
        report_test("dependency wait");

        test_errors = errors;
        base        = results;
        cdb_grant   = 1'b0;
        enqueue_op(1'b1, 4'd6, 32'h40, '0, '0);
        enqueue_op(1'b1, 4'd7, 32'h84, '0, '0);
        send_broadcasts(1'b0, 0);
        while (!load_out.valid) @(negedge clk);
        held = load_out;
        repeat (6) begin
            @(negedge clk);
            check_value("load_out", 64'(load_out), 64'(held));
        end
        cdb_grant = 1'b1;
        wait_idle();
        repeat (5) @(negedge clk);                         // Room for a stray result
        check_value("load results", 64'(results - base), 64'(2));
        report_test("back-pressure");

        test_errors = errors;
        @(posedge clk);
        rand_mode = 1'b1;
        @(negedge clk);
        remaining = RAND_OPS;
        while (remaining > 0) begin
            n = 1 + int'($urandom % `LSQ_DEPTH);
            if (n > remaining) n = remaining;
            for (int k = 0; k < n; k++) begin
                is_load = $urandom % 2;
                dtag    = ($urandom % 2) ? `TAG_W'(2 * k + 2) : '0;   // Data known or not
                addr    = ($urandom & 32'hffff_ff03) | ((32'($urandom) % 8) << 2);
                enqueue_op(is_load, `TAG_W'(2 * k + 1), addr, dtag, $urandom);
            end
            send_broadcasts(1'b1, 2);
            wait_idle();
            remaining -= n;
        end
        @(posedge clk);
        rand_mode = 1'b0;
        @(negedge clk);
        cdb_grant    = 1'b1;
        store_commit = 1'b0;
        report_test("random mix");

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsq_sys.f ====
+incdir+.
lsq_pkg.sv
lsq_entry.sv
lsq_alloc.sv
lsq_retire.sv
data_mem.sv
lsq_top.sv
lsq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsq_tb -f lsq_sys.f -o lsq_sim

if ./obj_dir/lsq_sim | tee /dev/stderr | grep -qx "Done: no errors"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
